//--- dcache_pkg.sv
package dcache_pkg;

   // Datapath and address widths
   localparam int dword_width       = 64;
   localparam int page_offset_width = 12;
   localparam int ptag_width        = 28;
   localparam int paddr_width       = ptag_width + page_offset_width;

   // Request opcodes, dword only
   typedef enum logic [0:0]
   {
      e_op_ld = 1'b0,
      e_op_sd = 1'b1
   } dcache_op_e;

   // Memory command opcodes
   typedef enum logic [0:0]
   {
      e_mem_rd = 1'b0,
      e_mem_wr = 1'b1
   } mem_op_e;

   // Fill sequencer
   typedef enum logic [1:0]
   {
      e_idle       = 2'd0,
      e_send_fill  = 2'd1,
      e_wait_fill  = 2'd2,
      e_write_fill = 2'd3
   } engine_state_e;

endpackage

//--- dcache_replay_fifo.sv
module dcache_replay_fifo
  #(parameter els_p = 8
   )
   (input  logic                                     clk_i
   ,input  logic                                     rst_n_i

   ,input  logic                                     v_i
   ,input  dcache_pkg::dcache_op_e                   op_i
   ,input  logic [dcache_pkg::page_offset_width-1:0] offset_i
   ,input  logic [dcache_pkg::dword_width-1:0]       data_i
   ,input  logic [dcache_pkg::ptag_width-1:0]        ptag_i
   ,output logic                                     ready_o

   ,output logic                                     issue_v_o
   ,output dcache_pkg::dcache_op_e                   issue_op_o
   ,output logic [dcache_pkg::page_offset_width-1:0] issue_offset_o
   ,output logic [dcache_pkg::dword_width-1:0]       issue_data_o
   ,output logic [dcache_pkg::ptag_width-1:0]        issue_ptag_o
   ,input  logic                                     issue_yumi_i

   ,input  logic                                     commit_i
   ,input  logic                                     rollback_i
   );

   localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;
   localparam int cnt_width_lp = $clog2(els_p + 1);
   localparam logic [ptr_width_lp-1:0] last_ptr_lp = ptr_width_lp'(els_p - 1);

   dcache_pkg::dcache_op_e                   op_mem     [els_p];
   logic [dcache_pkg::page_offset_width-1:0] offset_mem [els_p];
   logic [dcache_pkg::dword_width-1:0]       data_mem   [els_p];
   logic [dcache_pkg::ptag_width-1:0]        ptag_mem   [els_p];

   // Write, read (next to issue) and free (oldest uncommitted) pointers
   logic [ptr_width_lp-1:0] wptr_r;
   logic [ptr_width_lp-1:0] rptr_r;
   logic [ptr_width_lp-1:0] fptr_r;
   logic [cnt_width_lp-1:0] count_r;
   logic                    full;
   logic                    wr_en;

   function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] ptr);
      return (ptr == last_ptr_lp) ? '0 : ptr + 1'b1;
   endfunction

   assign full    = (count_r == cnt_width_lp'(els_p));
   assign ready_o = ~full;
   assign wr_en   = v_i & ready_o;

   // Full with read at free means nothing issued yet
   assign issue_v_o = (rptr_r != wptr_r) | (full & (rptr_r == fptr_r));

   assign issue_op_o     = op_mem[rptr_r];
   assign issue_offset_o = offset_mem[rptr_r];
   assign issue_data_o   = data_mem[rptr_r];
   assign issue_ptag_o   = ptag_mem[rptr_r];

   always_ff @(posedge clk_i)
   begin
      if (wr_en)
      begin
         op_mem[wptr_r]     <= op_i;
         offset_mem[wptr_r] <= offset_i;
         data_mem[wptr_r]   <= data_i;
         ptag_mem[wptr_r]   <= ptag_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wptr_r  <= '0;
         rptr_r  <= '0;
         fptr_r  <= '0;
         count_r <= '0;
      end
      else
      begin
         if (wr_en)
            wptr_r <= next_ptr(wptr_r);

         // Result valid retires the oldest entry
         if (commit_i)
            fptr_r <= next_ptr(fptr_r);

         // Rewind wins over a same-cycle issue
         if (rollback_i)
            rptr_r <= fptr_r;
         else if (issue_yumi_i)
            rptr_r <= next_ptr(rptr_r);

         count_r <= count_r + cnt_width_lp'(wr_en) - cnt_width_lp'(commit_i);
      end
   end

endmodule

//--- dcache_pipe.sv
module dcache_pipe
  #(parameter  sets_p       = 64
   ,localparam idx_width_lp = $clog2(sets_p)
   ,localparam tag_width_lp = dcache_pkg::paddr_width - idx_width_lp - 3
   )
   (input  logic                                     clk_i
   ,input  logic                                     rst_n_i

   ,input  logic                                     issue_v_i
   ,input  dcache_pkg::dcache_op_e                   issue_op_i
   ,input  logic [dcache_pkg::page_offset_width-1:0] issue_offset_i
   ,input  logic [dcache_pkg::dword_width-1:0]       issue_data_i
   ,input  logic [dcache_pkg::ptag_width-1:0]        issue_ptag_i
   ,output logic                                     issue_yumi_o

   ,output logic                                     v_o
   ,output logic [dcache_pkg::dword_width-1:0]       data_o
   ,output logic                                     commit_o
   ,output logic                                     poison_o

   ,output logic                                     miss_v_o
   ,output logic [dcache_pkg::paddr_width-1:0]       miss_addr_o

   ,output logic                                     wt_v_o
   ,output logic [dcache_pkg::paddr_width-1:0]       wt_addr_o
   ,output logic [dcache_pkg::dword_width-1:0]       wt_data_o
   ,input  logic                                     wt_ready_i

   ,input  logic                                     engine_busy_i
   ,input  logic                                     fill_v_i
   ,input  logic [idx_width_lp-1:0]                  fill_index_i
   ,input  logic [tag_width_lp-1:0]                  fill_tag_i
   ,input  logic [dcache_pkg::dword_width-1:0]       fill_data_i
   );

   // Tag and data arrays, one dword per line
   logic [tag_width_lp-1:0]            tag_mem  [sets_p];
   logic [dcache_pkg::dword_width-1:0] data_mem [sets_p];
   logic [sets_p-1:0]                  valid_r;

   // Stage 1
   logic                                     s1_v_r;
   dcache_pkg::dcache_op_e                   s1_op_r;
   logic [dcache_pkg::page_offset_width-1:0] s1_offset_r;
   logic [dcache_pkg::dword_width-1:0]       s1_data_r;
   logic [dcache_pkg::ptag_width-1:0]        s1_ptag_r;
   logic [idx_width_lp-1:0]                  s1_idx;

   // Stage 2
   logic                               s2_v_r;
   dcache_pkg::dcache_op_e             s2_op_r;
   logic [dcache_pkg::paddr_width-1:0] s2_paddr_r;
   logic [dcache_pkg::dword_width-1:0] s2_data_r;
   logic [tag_width_lp-1:0]            s2_tag_rd_r;
   logic [dcache_pkg::dword_width-1:0] s2_line_rd_r;
   logic                               s2_valid_rd_r;
   logic [idx_width_lp-1:0]            s2_idx;
   logic [tag_width_lp-1:0]            s2_tag;

   logic is_ld;
   logic hit;
   logic store_hit_wr;
   logic fwd;

   assign s1_idx = s1_offset_r[3 +: idx_width_lp];
   assign s2_idx = s2_paddr_r[3 +: idx_width_lp];
   assign s2_tag = s2_paddr_r[dcache_pkg::paddr_width-1 -: tag_width_lp];

   assign is_ld = (s2_op_r == dcache_pkg::e_op_ld);
   assign hit   = s2_valid_rd_r & (s2_tag_rd_r == s2_tag);

   assign miss_v_o    = s2_v_r & is_ld & ~hit;
   assign miss_addr_o = s2_paddr_r;

   // Stores always go through, but only when the engine can take them
   assign wt_v_o    = s2_v_r & ~is_ld & wt_ready_i;
   assign wt_addr_o = s2_paddr_r;
   assign wt_data_o = s2_data_r;

   assign v_o      = (s2_v_r & is_ld & hit) | wt_v_o;
   assign data_o   = is_ld ? s2_line_rd_r : '0;
   assign commit_o = v_o;
   assign poison_o = s2_v_r & ~v_o;

   assign issue_yumi_o = issue_v_i & ~engine_busy_i & ~poison_o;

   // Store hit updates the line; stage 1 reading the same set sees the new data
   assign store_hit_wr = wt_v_o & hit;
   assign fwd          = store_hit_wr & (s2_idx == s1_idx);

   always_ff @(posedge clk_i)
   begin
      if (fill_v_i)
      begin
         tag_mem[fill_index_i]  <= fill_tag_i;
         data_mem[fill_index_i] <= fill_data_i;
      end
      else if (store_hit_wr)
         data_mem[s2_idx] <= s2_data_r;
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         valid_r <= '0;
      else if (fill_v_i)
         valid_r[fill_index_i] <= 1'b1;
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         s1_v_r <= 1'b0;
         s2_v_r <= 1'b0;
      end
      else
      begin
         // Poison flushes the younger request too
         s1_v_r <= issue_yumi_o;
         s2_v_r <= s1_v_r & ~poison_o;
      end
   end

   always_ff @(posedge clk_i)
   begin
      s1_op_r     <= issue_op_i;
      s1_offset_r <= issue_offset_i;
      s1_data_r   <= issue_data_i;
      s1_ptag_r   <= issue_ptag_i;

      s2_op_r       <= s1_op_r;
      s2_paddr_r    <= {s1_ptag_r, s1_offset_r};
      s2_data_r     <= s1_data_r;
      s2_tag_rd_r   <= tag_mem[s1_idx];
      s2_line_rd_r  <= fwd ? s2_data_r : data_mem[s1_idx];
      s2_valid_rd_r <= valid_r[s1_idx];
   end

endmodule

//--- dcache_mem_engine.sv
module dcache_mem_engine
  #(parameter  sets_p       = 64
   ,localparam idx_width_lp = $clog2(sets_p)
   ,localparam tag_width_lp = dcache_pkg::paddr_width - idx_width_lp - 3
   )
   (input  logic                               clk_i
   ,input  logic                               rst_n_i

   ,input  logic                               miss_v_i
   ,input  logic [dcache_pkg::paddr_width-1:0] miss_addr_i

   ,input  logic                               wt_v_i
   ,input  logic [dcache_pkg::paddr_width-1:0] wt_addr_i
   ,input  logic [dcache_pkg::dword_width-1:0] wt_data_i
   ,output logic                               wt_ready_o

   ,output logic                               busy_o
   ,output logic                               fill_v_o
   ,output logic [idx_width_lp-1:0]            fill_index_o
   ,output logic [tag_width_lp-1:0]            fill_tag_o
   ,output logic [dcache_pkg::dword_width-1:0] fill_data_o

   ,output logic                               mem_cmd_v_o
   ,output dcache_pkg::mem_op_e                mem_cmd_op_o
   ,output logic [dcache_pkg::paddr_width-1:0] mem_cmd_addr_o
   ,output logic [dcache_pkg::dword_width-1:0] mem_cmd_data_o
   ,input  logic                               mem_cmd_ready_i

   ,input  logic                               mem_resp_v_i
   ,input  logic [dcache_pkg::dword_width-1:0] mem_resp_data_i
   ,output logic                               mem_resp_yumi_o
   );

   dcache_pkg::engine_state_e state_r;

   logic [dcache_pkg::paddr_width-1:0] miss_addr_r;
   logic [dcache_pkg::dword_width-1:0] fill_data_r;

   // One-entry write-through buffer
   logic                               wbuf_v_r;
   logic [dcache_pkg::paddr_width-1:0] wbuf_addr_r;
   logic [dcache_pkg::dword_width-1:0] wbuf_data_r;

   assign wt_ready_o = (state_r == dcache_pkg::e_idle) & ~wbuf_v_r;
   assign busy_o     = (state_r != dcache_pkg::e_idle);

   // A pending write always goes out ahead of the fill read
   assign mem_cmd_v_o    = wbuf_v_r | (state_r == dcache_pkg::e_send_fill);
   assign mem_cmd_op_o   = wbuf_v_r ? dcache_pkg::e_mem_wr : dcache_pkg::e_mem_rd;
   assign mem_cmd_addr_o = wbuf_v_r ? wbuf_addr_r : miss_addr_r;
   assign mem_cmd_data_o = wbuf_v_r ? wbuf_data_r : '0;

   assign mem_resp_yumi_o = (state_r == dcache_pkg::e_wait_fill) & mem_resp_v_i;

   assign fill_v_o     = (state_r == dcache_pkg::e_write_fill);
   assign fill_index_o = miss_addr_r[3 +: idx_width_lp];
   assign fill_tag_o   = miss_addr_r[dcache_pkg::paddr_width-1 -: tag_width_lp];
   assign fill_data_o  = fill_data_r;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_r  <= dcache_pkg::e_idle;
         wbuf_v_r <= 1'b0;
      end
      else
      begin
         case (state_r)
            dcache_pkg::e_idle:
               if (miss_v_i)
                  state_r <= dcache_pkg::e_send_fill;
            dcache_pkg::e_send_fill:
               if (~wbuf_v_r & mem_cmd_ready_i)
                  state_r <= dcache_pkg::e_wait_fill;
            dcache_pkg::e_wait_fill:
               if (mem_resp_yumi_o)
                  state_r <= dcache_pkg::e_write_fill;
            dcache_pkg::e_write_fill:
               state_r <= dcache_pkg::e_idle;
         endcase

         if (wt_v_i)
            wbuf_v_r <= 1'b1;
         else if (mem_cmd_ready_i)
            wbuf_v_r <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (miss_v_i)
         miss_addr_r <= miss_addr_i;

      if (wt_v_i)
      begin
         wbuf_addr_r <= wt_addr_i;
         wbuf_data_r <= wt_data_i;
      end

      if (mem_resp_yumi_o)
         fill_data_r <= mem_resp_data_i;
   end

endmodule

//--- dcache_top.sv
module dcache_top
  #(parameter replay_els_p = 8
   ,parameter sets_p       = 64
   )
   (input  logic                                     clk_i
   ,input  logic                                     rst_n_i

   ,input  logic                                     v_i
   ,input  dcache_pkg::dcache_op_e                   op_i
   ,input  logic [dcache_pkg::page_offset_width-1:0] offset_i
   ,input  logic [dcache_pkg::dword_width-1:0]       data_i
   ,input  logic [dcache_pkg::ptag_width-1:0]        ptag_i
   ,output logic                                     ready_o

   ,output logic                                     v_o
   ,output logic [dcache_pkg::dword_width-1:0]       data_o

   ,output logic                                     mem_cmd_v_o
   ,output dcache_pkg::mem_op_e                      mem_cmd_op_o
   ,output logic [dcache_pkg::paddr_width-1:0]       mem_cmd_addr_o
   ,output logic [dcache_pkg::dword_width-1:0]       mem_cmd_data_o
   ,input  logic                                     mem_cmd_ready_i

   ,input  logic                                     mem_resp_v_i
   ,input  logic [dcache_pkg::dword_width-1:0]       mem_resp_data_i
   ,output logic                                     mem_resp_yumi_o
   );

   localparam int idx_width_lp = $clog2(sets_p);
   localparam int tag_width_lp = dcache_pkg::paddr_width - idx_width_lp - 3;

   // Queue to pipeline
   logic                                     issue_v;
   dcache_pkg::dcache_op_e                   issue_op;
   logic [dcache_pkg::page_offset_width-1:0] issue_offset;
   logic [dcache_pkg::dword_width-1:0]       issue_data;
   logic [dcache_pkg::ptag_width-1:0]        issue_ptag;
   logic                                     issue_yumi;
   logic                                     commit;
   logic                                     poison;

   // Pipeline to engine
   logic                               miss_v;
   logic [dcache_pkg::paddr_width-1:0] miss_addr;
   logic                               wt_v;
   logic [dcache_pkg::paddr_width-1:0] wt_addr;
   logic [dcache_pkg::dword_width-1:0] wt_data;
   logic                               wt_ready;
   logic                               engine_busy;
   logic                               fill_v;
   logic [idx_width_lp-1:0]            fill_index;
   logic [tag_width_lp-1:0]            fill_tag;
   logic [dcache_pkg::dword_width-1:0] fill_data;

   dcache_replay_fifo
    #(.els_p(replay_els_p))
    replay
    (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.v_i(v_i)
    ,.op_i(op_i)
    ,.offset_i(offset_i)
    ,.data_i(data_i)
    ,.ptag_i(ptag_i)
    ,.ready_o(ready_o)
    ,.issue_v_o(issue_v)
    ,.issue_op_o(issue_op)
    ,.issue_offset_o(issue_offset)
    ,.issue_data_o(issue_data)
    ,.issue_ptag_o(issue_ptag)
    ,.issue_yumi_i(issue_yumi)
    ,.commit_i(commit)
    ,.rollback_i(poison)
    );

   dcache_pipe
    #(.sets_p(sets_p))
    pipe
    (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.issue_v_i(issue_v)
    ,.issue_op_i(issue_op)
    ,.issue_offset_i(issue_offset)
    ,.issue_data_i(issue_data)
    ,.issue_ptag_i(issue_ptag)
    ,.issue_yumi_o(issue_yumi)
    ,.v_o(v_o)
    ,.data_o(data_o)
    ,.commit_o(commit)
    ,.poison_o(poison)
    ,.miss_v_o(miss_v)
    ,.miss_addr_o(miss_addr)
    ,.wt_v_o(wt_v)
    ,.wt_addr_o(wt_addr)
    ,.wt_data_o(wt_data)
    ,.wt_ready_i(wt_ready)
    ,.engine_busy_i(engine_busy)
    ,.fill_v_i(fill_v)
    ,.fill_index_i(fill_index)
    ,.fill_tag_i(fill_tag)
    ,.fill_data_i(fill_data)
    );

   dcache_mem_engine
    #(.sets_p(sets_p))
    engine
    (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.miss_v_i(miss_v)
    ,.miss_addr_i(miss_addr)
    ,.wt_v_i(wt_v)
    ,.wt_addr_i(wt_addr)
    ,.wt_data_i(wt_data)
    ,.wt_ready_o(wt_ready)
    ,.busy_o(engine_busy)
    ,.fill_v_o(fill_v)
    ,.fill_index_o(fill_index)
    ,.fill_tag_o(fill_tag)
    ,.fill_data_o(fill_data)
    ,.mem_cmd_v_o(mem_cmd_v_o)
    ,.mem_cmd_op_o(mem_cmd_op_o)
    ,.mem_cmd_addr_o(mem_cmd_addr_o)
    ,.mem_cmd_data_o(mem_cmd_data_o)
    ,.mem_cmd_ready_i(mem_cmd_ready_i)
    ,.mem_resp_v_i(mem_resp_v_i)
    ,.mem_resp_data_i(mem_resp_data_i)
    ,.mem_resp_yumi_o(mem_resp_yumi_o)
    );

endmodule

//--- tb_dcache_top.sv
module tb_dcache_top;

   localparam int replay_els_lp  = 8;
   localparam int sets_lp        = 64;
   localparam int drive_delay_lp = 10;
   localparam int timeout_lp     = 2000;

   typedef logic [dcache_pkg::paddr_width-1:0] paddr_t;
   typedef logic [dcache_pkg::dword_width-1:0] dword_t;

   localparam paddr_t cold_addr_lp  = 40'h00_0abc_d040;
   localparam paddr_t stall_st_lp   = 40'h00_0777_0100;
   localparam paddr_t stall_miss_lp = 40'h00_0888_0208;

   logic                                     clk_i   = 1'b0;
   logic                                     rst_n_i = 1'b0;
   logic                                     v_i;
   dcache_pkg::dcache_op_e                   op_i;
   logic [dcache_pkg::page_offset_width-1:0] offset_i;
   dword_t                                   data_i;
   logic [dcache_pkg::ptag_width-1:0]        ptag_i;
   logic                                     ready_o;
   logic                                     v_o;
   dword_t                                   data_o;
   logic                                     mem_cmd_v_o;
   dcache_pkg::mem_op_e                      mem_cmd_op_o;
   paddr_t                                   mem_cmd_addr_o;
   dword_t                                   mem_cmd_data_o;
   logic                                     mem_cmd_ready_i;
   logic                                     mem_resp_v_i;
   dword_t                                   mem_resp_data_i;
   logic                                     mem_resp_yumi_o;

   int seed = 32'hde8c;

   // Memory model
   dword_t mem [paddr_t];
   int     rd_count [paddr_t];
   int     wr_seen = 0;
   dword_t rd_q [$];
   int     resp_delay = 0;
   int     stall_cycles = 0;
   logic   rand_ready = 1'b0;
   logic   ready_next = 1'b1;

   // Scoreboard in program order
   dword_t shadow [paddr_t];
   dword_t exp_q [$];
   paddr_t exp_wr_addr_q [$];
   dword_t exp_wr_data_q [$];
   logic   exp_v = 1'b0;
   dword_t exp_data = '0;
   logic   exp_wr_v = 1'b0;
   paddr_t exp_wr_addr = '0;
   dword_t exp_wr_data = '0;
   int     outstanding = 0;
   int     outstanding_cur = 0;
   logic   saw_full = 1'b0;

   dcache_top
    #(.replay_els_p(replay_els_lp)
     ,.sets_p(sets_lp))
    dut0
    (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.v_i(v_i)
    ,.op_i(op_i)
    ,.offset_i(offset_i)
    ,.data_i(data_i)
    ,.ptag_i(ptag_i)
    ,.ready_o(ready_o)
    ,.v_o(v_o)
    ,.data_o(data_o)
    ,.mem_cmd_v_o(mem_cmd_v_o)
    ,.mem_cmd_op_o(mem_cmd_op_o)
    ,.mem_cmd_addr_o(mem_cmd_addr_o)
    ,.mem_cmd_data_o(mem_cmd_data_o)
    ,.mem_cmd_ready_i(mem_cmd_ready_i)
    ,.mem_resp_v_i(mem_resp_v_i)
    ,.mem_resp_data_i(mem_resp_data_i)
    ,.mem_resp_yumi_o(mem_resp_yumi_o)
    );

   always #50 clk_i = ~clk_i;

   function automatic dword_t init_value(input paddr_t addr);
      return dword_t'(addr) ^ 64'h5a5a_0000_5a5a_0000;
   endfunction

   function automatic dword_t mem_value(input paddr_t addr);
      return mem.exists(addr) ? mem[addr] : init_value(addr);
   endfunction

   function automatic dword_t ref_value(input paddr_t addr);
      return shadow.exists(addr) ? shadow[addr] : init_value(addr);
   endfunction

   // Sets 1 and 2 each see two or more tags
   function automatic paddr_t pool_addr(input int k);
      case (k)
         0:       return 40'h00_0000_1008;
         1:       return 40'h00_0000_2008;
         2:       return 40'h00_0000_3008;
         3:       return 40'h00_0000_1010;
         4:       return 40'h00_0000_1018;
         default: return 40'h12_3456_7010;
      endcase
   endfunction

   task automatic report_error(input string msg);
      $display("error at time %0t: %s", $time, msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic report_timeout(input string what);
      $display("timed out waiting for %s", what);
      $display("Simulation failed");
      $fatal(1);
   endtask

   a_reset_outputs: assert property (@(posedge clk_i)
      $rose(rst_n_i) |-> !v_o && !mem_cmd_v_o && !mem_resp_yumi_o && ready_o)
      else report_error("outputs not idle in the cycle after reset release");

   a_result_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      v_o |-> exp_v && (data_o == exp_data))
      else report_error("result missing from scoreboard or data differs");

   a_write_cmd: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_cmd_v_o && mem_cmd_ready_i && (mem_cmd_op_o == dcache_pkg::e_mem_wr)
      |-> exp_wr_v && (mem_cmd_addr_o == exp_wr_addr) && (mem_cmd_data_o == exp_wr_data))
      else report_error("write-through command differs from store");

   a_cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_cmd_v_o && !mem_cmd_ready_i |=> mem_cmd_v_o && $stable(mem_cmd_op_o)
      && $stable(mem_cmd_addr_o) && $stable(mem_cmd_data_o))
      else report_error("memory command changed while not accepted");

   a_ready_level: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ready_o == (outstanding_cur < replay_els_lp))
      else report_error("ready_o does not match queue occupancy");

   // Handshakes are decided mid-cycle, for the coming edge
   always @(negedge clk_i)
   begin
      paddr_t req_addr;
      outstanding_cur = outstanding;
      if (outstanding_cur == replay_els_lp)
         saw_full = 1'b1;

      exp_v    = v_o && (exp_q.size() > 0);
      exp_data = (exp_q.size() > 0) ? exp_q[0] : '0;
      if (exp_v)
      begin
         void'(exp_q.pop_front());
         outstanding--;
      end

      if (v_i && ready_o && rst_n_i)
      begin
         req_addr = {ptag_i, offset_i};
         if (op_i == dcache_pkg::e_op_ld)
            exp_q.push_back(ref_value(req_addr));
         else
         begin
            exp_q.push_back('0);
            shadow[req_addr] = data_i;
            exp_wr_addr_q.push_back(req_addr);
            exp_wr_data_q.push_back(data_i);
         end
         outstanding++;
      end

      if (mem_resp_v_i && mem_resp_yumi_o)
      begin
         void'(rd_q.pop_front());
         if (rd_q.size() > 0)
            resp_delay = 1 + ($unsigned($random(seed)) % 6);
      end
      else if ((rd_q.size() > 0) && (resp_delay > 0))
         resp_delay--;

      exp_wr_v = 1'b0;
      if (mem_cmd_v_o && mem_cmd_ready_i && rst_n_i)
      begin
         if (mem_cmd_op_o == dcache_pkg::e_mem_wr)
         begin
            exp_wr_v = (exp_wr_addr_q.size() > 0);
            if (exp_wr_v)
            begin
               exp_wr_addr = exp_wr_addr_q.pop_front();
               exp_wr_data = exp_wr_data_q.pop_front();
            end
            mem[mem_cmd_addr_o] = mem_cmd_data_o;
            wr_seen++;
         end
         else
         begin
            if (rd_q.size() == 0)
               resp_delay = 1 + ($unsigned($random(seed)) % 6);
            rd_q.push_back(mem_value(mem_cmd_addr_o));
            if (rd_count.exists(mem_cmd_addr_o))
               rd_count[mem_cmd_addr_o]++;
            else
               rd_count[mem_cmd_addr_o] = 1;
         end
      end

      if (stall_cycles > 0)
      begin
         ready_next = 1'b0;
         stall_cycles--;
      end
      else if (rand_ready)
         ready_next = ($unsigned($random(seed)) % 4) != 0;
      else
         ready_next = 1'b1;
   end

   initial
   begin
      mem_cmd_ready_i = 1'b0;
      mem_resp_v_i    = 1'b0;
      mem_resp_data_i = '0;
      forever
      begin
         @(posedge clk_i);
         #drive_delay_lp;
         mem_cmd_ready_i = ready_next;
         mem_resp_v_i    = (rd_q.size() > 0) && (resp_delay == 0);
         mem_resp_data_i = (rd_q.size() > 0) ? rd_q[0] : '0;
      end
   end

   task automatic send_req(input dcache_pkg::dcache_op_e op, input paddr_t addr,
                           input dword_t data);
      int cycles;
      cycles   = 0;
      v_i      = 1'b1;
      op_i     = op;
      offset_i = addr[dcache_pkg::page_offset_width-1:0];
      ptag_i   = addr[dcache_pkg::paddr_width-1:dcache_pkg::page_offset_width];
      data_i   = data;
      @(negedge clk_i);
      while (!ready_o)
      begin
         if (cycles == timeout_lp)
            report_timeout("the replay queue to accept a request");
         cycles++;
         @(negedge clk_i);
      end
      @(posedge clk_i);
      #drive_delay_lp;
      v_i = 1'b0;
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while ((exp_q.size() != 0) || (exp_wr_addr_q.size() != 0))
      begin
         if (cycles == timeout_lp)
            report_timeout("outstanding results and write-through commands");
         cycles++;
         @(posedge clk_i);
         #drive_delay_lp;
      end
   endtask

   initial
   begin
      int     n;
      dword_t wdata;
      v_i      = 1'b0;
      op_i     = dcache_pkg::e_op_ld;
      offset_i = '0;
      data_i   = '0;
      ptag_i   = '0;
      repeat (5) @(posedge clk_i);
      #drive_delay_lp;
      rst_n_i = 1'b1;
      @(posedge clk_i);
      #drive_delay_lp;

      // Cold miss, then a hit on the filled line
      send_req(dcache_pkg::e_op_ld, cold_addr_lp, '0);
      wait_drain();
      assert (rd_count.exists(cold_addr_lp) && (rd_count[cold_addr_lp] == 1))
         else report_error("cold load did not issue exactly one memory read");
      send_req(dcache_pkg::e_op_ld, cold_addr_lp, '0);
      send_req(dcache_pkg::e_op_sd, cold_addr_lp, 64'hc0ff_ee00_1234_5678);
      send_req(dcache_pkg::e_op_ld, cold_addr_lp, '0);
      wait_drain();
      assert (wr_seen == 1)
         else report_error("store produced no single write-through command");
      assert (rd_count[cold_addr_lp] == 1)
         else report_error("hit on a filled line issued a memory read");

      // Mixed stream with random command back-pressure
      rand_ready = 1'b1;
      for (n = 0; n < 200; n++)
      begin
         wdata = {$random(seed), $random(seed)};
         if (($unsigned($random(seed)) % 4) != 0)
            send_req((($unsigned($random(seed)) % 2) != 0) ? dcache_pkg::e_op_sd
                     : dcache_pkg::e_op_ld, pool_addr($unsigned($random(seed)) % 6), wdata);
         else
         begin
            @(posedge clk_i);
            #drive_delay_lp;
         end
      end
      wait_drain();
      rand_ready = 1'b0;

      // Held command fills the queue
      stall_cycles = 60;
      send_req(dcache_pkg::e_op_sd, stall_st_lp, 64'h0123_4567_89ab_cdef);
      send_req(dcache_pkg::e_op_ld, stall_miss_lp, '0);
      for (n = 0; n < 10; n++)
         send_req(dcache_pkg::e_op_ld, pool_addr(n % 6), '0);
      wait_drain();
      assert (saw_full)
         else report_error("replay queue never reached full occupancy");

      $display("Simulation passed");
      $finish;
   end

endmodule

//--- all.f
dcache_pkg.sv
dcache_replay_fifo.sv
dcache_pipe.sv
dcache_mem_engine.sv
dcache_top.sv
tb_dcache_top.sv

//--- Bender.yml
package:
  name: dcache_top

sources:
  - dcache_pkg.sv
  - dcache_replay_fifo.sv
  - dcache_pipe.sv
  - dcache_mem_engine.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_dcache_top.sv
